// ==== verilog/frame_fifo_macros.svh ====
// FIFO sizes shared by the packages and RTL. Include this before `default_nettype none
// FIFO_KEEP_WIDTH assumes whole bytes, so FIFO_DATA_WIDTH must be a multiple of 8
`ifndef FRAME_FIFO_MACROS_SVH
`define FRAME_FIFO_MACROS_SVH

`default_nettype none

// memory depth is 2**FIFO_ADDR_WIDTH words, a frame cannot exceed it
`define FIFO_ADDR_WIDTH 6

`define FIFO_DATA_WIDTH 64

`define FIFO_KEEP_WIDTH (`FIFO_DATA_WIDTH / 8)

// 1 keeps the input always ready and drops frames once memory fills
`define FIFO_DROP_WHEN_FULL 0

`default_nettype wire

`endif

// ==== verilog/axis_stream_pkg.sv ====
// stream-side types, one memory word holds tlast, tkeep and tdata of a beat
`include "frame_fifo_macros.svh"
`default_nettype none

package axis_stream_pkg;
    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
    typedef logic [`FIFO_KEEP_WIDTH-1:0] keep_t;

    typedef struct packed {
        logic  last;
        keep_t keep;
        data_t data;
    } fifo_word_t;

    typedef enum logic [1:0] {EV_NONE, EV_GOOD, EV_BAD, EV_OVERFLOW} frame_event_e;
endpackage

`default_nettype wire

// ==== verilog/fifo_ctrl_pkg.sv ====
// pointer types for the dual-clock FIFO
// pointers carry one wrap bit above the address, in binary and Gray form alike
`include "frame_fifo_macros.svh"
`default_nettype none

package fifo_ctrl_pkg;
    typedef logic [`FIFO_ADDR_WIDTH:0]   ptr_t;
    typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

    // WR_DROP discards the rest of a frame that cannot be stored
    typedef enum logic {
        WR_ACCEPT,
        WR_DROP
    } wr_state_e;

    // only one bit changes per increment, safe to sample in the other domain
    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction
endpackage

`default_nettype wire

// ==== verilog/fifo_reset_sync.sv ====
// one reset per clock domain from a shared asynchronous reset
// each side leaves reset three own-clock cycles after release, and never before the other
`include "frame_fifo_macros.svh"
`default_nettype none

module fifo_reset_sync (
    input  wire  async_rst,
    input  wire  input_clk,
    input  wire  output_clk,
    output logic input_rst,
    output logic output_rst
);
    logic in_sync1;
    logic in_sync2;
    logic out_sync1;
    logic out_sync2;

    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_sync1  <= 1'b1;
            in_sync2  <= 1'b1;
            input_rst <= 1'b1;
        end else begin
            in_sync1  <= 1'b0;
            // held while either first stage still sees reset
            in_sync2  <= in_sync1 | out_sync1;
            input_rst <= in_sync2;
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_sync1  <= 1'b1;
            out_sync2  <= 1'b1;
            output_rst <= 1'b1;
        end else begin
            out_sync1  <= 1'b0;
            out_sync2  <= in_sync1 | out_sync1;
            output_rst <= out_sync2;
        end
    end

    assert property (@(posedge input_clk) async_rst |-> input_rst);
endmodule

`default_nettype wire

// ==== verilog/frame_fifo_ram.sv ====
// simple dual-port frame memory, write on input_clk and read on output_clk
// read data appears one output_clk cycle after an enabled read and has no reset value
`include "frame_fifo_macros.svh"
`default_nettype none

module frame_fifo_ram (
    input  wire                              input_clk,
    input  wire                              output_clk,
    input  wire                              ram_wr_en,
    input  wire fifo_ctrl_pkg::addr_t        ram_wr_addr,
    input  wire axis_stream_pkg::fifo_word_t ram_wr_data,
    input  wire                              ram_rd_en,
    input  wire fifo_ctrl_pkg::addr_t        ram_rd_addr,
    output axis_stream_pkg::fifo_word_t      ram_rd_data
);
    import axis_stream_pkg::*;
    import fifo_ctrl_pkg::*;

    fifo_word_t mem [2**$bits(addr_t)];

    always_ff @(posedge input_clk) begin
        if (ram_wr_en) begin
            mem[ram_wr_addr] <= ram_wr_data;
        end
    end

    // read register holds while the output stage is stalled
    always_ff @(posedge output_clk) begin
        if (ram_rd_en) begin
            ram_rd_data <= mem[ram_rd_addr];
        end
    end
endmodule

`default_nettype wire

// ==== verilog/frame_write_ctrl.sv ====
// input-domain frame writer, a frame becomes visible only on a good tlast
// bad, oversize or (with drop-when-full) blocked frames are rewound and reported
`include "frame_fifo_macros.svh"
`default_nettype none

module frame_write_ctrl (
    input  wire                         input_clk,
    input  wire                         input_rst,
    input  wire axis_stream_pkg::data_t input_axis_tdata,
    input  wire axis_stream_pkg::keep_t input_axis_tkeep,
    input  wire                         input_axis_tvalid,
    input  wire                         input_axis_tlast,
    input  wire                         input_axis_tuser,
    output logic                        input_axis_tready,
    input  wire fifo_ctrl_pkg::ptr_t    rd_ptr_gray,
    output fifo_ctrl_pkg::ptr_t         wr_ptr_gray,
    output logic                        ram_wr_en,
    output fifo_ctrl_pkg::addr_t        ram_wr_addr,
    output axis_stream_pkg::fifo_word_t ram_wr_data,
    output logic                        status_good,
    output logic                        status_bad,
    output logic                        status_overflow
);
    import axis_stream_pkg::*;
    import fifo_ctrl_pkg::*;

    ptr_t         wr_ptr;
    ptr_t         wr_ptr_cur;
    ptr_t         cur_inc;
    ptr_t         cur_gray;
    ptr_t         rd_gray_sync1;
    ptr_t         rd_gray_sync2;
    wr_state_e    state;
    frame_event_e ev;
    logic         accept_en;
    logic         full;
    logic         full_cur;
    logic         dropping;
    logic         accept;

    assign cur_inc  = wr_ptr_cur + 1'b1;
    assign cur_gray = bin2gray(wr_ptr_cur);

    // current pointer a whole lap ahead of the reader, Gray form
    assign full = (cur_gray[`FIFO_ADDR_WIDTH] != rd_gray_sync2[`FIFO_ADDR_WIDTH]) &&
                  (cur_gray[`FIFO_ADDR_WIDTH-1] != rd_gray_sync2[`FIFO_ADDR_WIDTH-1]) &&
                  (cur_gray[`FIFO_ADDR_WIDTH-2:0] == rd_gray_sync2[`FIFO_ADDR_WIDTH-2:0]);
    // frame already fills the whole memory, it can never commit
    assign full_cur = (wr_ptr_cur[`FIFO_ADDR_WIDTH] != wr_ptr[`FIFO_ADDR_WIDTH]) &&
                      (wr_ptr_cur[`FIFO_ADDR_WIDTH-1:0] == wr_ptr[`FIFO_ADDR_WIDTH-1:0]);
    assign dropping = (state == WR_DROP) || full_cur ||
                      (full && (`FIFO_DROP_WHEN_FULL != 0));

    // doomed beats are always taken, so an oversize frame cannot deadlock the input
    assign input_axis_tready = accept_en && (!full || dropping);
    assign accept            = input_axis_tvalid && input_axis_tready;

    assign ram_wr_en   = accept && !dropping;
    assign ram_wr_addr = wr_ptr_cur[`FIFO_ADDR_WIDTH-1:0];
    assign ram_wr_data = '{last: input_axis_tlast, keep: input_axis_tkeep,
                           data: input_axis_tdata};

    always_comb begin
        ev = EV_NONE;
        if (accept && input_axis_tlast) begin
            if (dropping) begin
                ev = EV_OVERFLOW;
            end else if (input_axis_tuser) begin
                ev = EV_BAD;
            end else begin
                ev = EV_GOOD;
            end
        end
    end

    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            wr_ptr          <= '0;
            wr_ptr_cur      <= '0;
            wr_ptr_gray     <= '0;
            rd_gray_sync1   <= '0;
            rd_gray_sync2   <= '0;
            state           <= WR_ACCEPT;
            accept_en       <= 1'b0;
            status_good     <= 1'b0;
            status_bad      <= 1'b0;
            status_overflow <= 1'b0;
        end else begin
            accept_en       <= 1'b1;
            rd_gray_sync1   <= rd_ptr_gray;
            rd_gray_sync2   <= rd_gray_sync1;
            status_good     <= (ev == EV_GOOD);
            status_bad      <= (ev == EV_BAD);
            status_overflow <= (ev == EV_OVERFLOW);
            if (accept && dropping) begin
                state <= input_axis_tlast ? WR_ACCEPT : WR_DROP;
            end
            if (ram_wr_en) begin
                wr_ptr_cur <= cur_inc;
            end
            // commit or rewind, the rewind overrides the advance above
            if (ev == EV_GOOD) begin
                wr_ptr      <= cur_inc;
                wr_ptr_gray <= bin2gray(cur_inc);
            end else if (ev != EV_NONE) begin
                wr_ptr_cur <= wr_ptr;
            end
        end
    end

    // unread data is never overwritten, judged against the live read pointer
    assert property (@(posedge input_clk) disable iff (input_rst)
        ram_wr_en |-> cur_gray != {~rd_ptr_gray[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                                   rd_ptr_gray[`FIFO_ADDR_WIDTH-2:0]});
    assert property (@(posedge input_clk) disable iff (input_rst)
        $onehot0({status_good, status_bad, status_overflow}));
endmodule

`default_nettype wire

// ==== verilog/frame_read_ctrl.sv ====
// output-domain reader, sees only committed frames through the synchronized write pointer
// two-stage pipeline (memory register, output register) that stalls as a unit on tready
`include "frame_fifo_macros.svh"
`default_nettype none

module frame_read_ctrl (
    input  wire                              output_clk,
    input  wire                              output_rst,
    input  wire fifo_ctrl_pkg::ptr_t         wr_ptr_gray,
    output fifo_ctrl_pkg::ptr_t              rd_ptr_gray,
    output logic                             ram_rd_en,
    output fifo_ctrl_pkg::addr_t             ram_rd_addr,
    input  wire axis_stream_pkg::fifo_word_t ram_rd_data,
    output axis_stream_pkg::data_t           output_axis_tdata,
    output axis_stream_pkg::keep_t           output_axis_tkeep,
    output logic                             output_axis_tvalid,
    output logic                             output_axis_tlast,
    input  wire                              output_axis_tready
);
    import axis_stream_pkg::*;
    import fifo_ctrl_pkg::*;

    ptr_t       rd_ptr;
    ptr_t       rd_ptr_inc;
    ptr_t       wr_gray_sync1;
    ptr_t       wr_gray_sync2;
    logic       empty;
    logic       advance;
    logic       rd_valid;
    fifo_word_t out_word;

    assign empty      = (rd_ptr_gray == wr_gray_sync2);
    // output register is free or being taken this cycle
    assign advance    = output_axis_tready || !output_axis_tvalid;
    assign ram_rd_en  = advance && !empty;
    assign ram_rd_addr = rd_ptr[`FIFO_ADDR_WIDTH-1:0];
    assign rd_ptr_inc = rd_ptr + 1'b1;

    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            rd_ptr             <= '0;
            rd_ptr_gray        <= '0;
            wr_gray_sync1      <= '0;
            wr_gray_sync2      <= '0;
            rd_valid           <= 1'b0;
            output_axis_tvalid <= 1'b0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
            if (ram_rd_en) begin
                rd_ptr      <= rd_ptr_inc;
                rd_ptr_gray <= bin2gray(rd_ptr_inc);
            end
            // valid flag tracks the word sitting in the memory read register
            if (advance) begin
                rd_valid           <= !empty;
                output_axis_tvalid <= rd_valid;
            end
        end
    end

    always_ff @(posedge output_clk) begin
        if (advance) begin
            out_word <= ram_rd_data;
        end
    end

    assign output_axis_tdata = out_word.data;
    assign output_axis_tkeep = out_word.keep;
    assign output_axis_tlast = out_word.last;

    // held beat must survive a stall of the whole read pipeline
    assert property (@(posedge output_clk) disable iff (output_rst)
        output_axis_tvalid && !output_axis_tready |=> output_axis_tvalid && $stable(out_word));
endmodule

`default_nettype wire

// ==== verilog/frame_status_sync.sv ====
// carries good, bad and overflow pulses from input_clk to output_clk
// pulses of one kind must be at least one output_clk period apart to be counted apart
`include "frame_fifo_macros.svh"
`default_nettype none

module frame_status_sync (
    input  wire  input_clk,
    input  wire  input_rst,
    input  wire  output_clk,
    input  wire  output_rst,
    input  wire  status_good,
    input  wire  status_bad,
    input  wire  status_overflow,
    output logic output_status_good,
    output logic output_status_bad,
    output logic output_status_overflow
);
    logic [2:0] in_toggle;
    logic [2:0] out_sync1;
    logic [2:0] out_sync2;
    logic [2:0] out_sync3;

    // one toggle per event kind, bit order overflow, bad, good
    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            in_toggle <= '0;
        end else begin
            in_toggle <= in_toggle ^ {status_overflow, status_bad, status_good};
        end
    end

    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            out_sync1 <= '0;
            out_sync2 <= '0;
            out_sync3 <= '0;
        end else begin
            out_sync1 <= in_toggle;
            out_sync2 <= out_sync1;
            out_sync3 <= out_sync2;
        end
    end

    // each toggle edge gives one output_clk pulse
    assign {output_status_overflow, output_status_bad, output_status_good} =
        out_sync2 ^ out_sync3;
endmodule

`default_nettype wire

// ==== verilog/axis_async_frame_fifo_64.sv ====
// dual-clock AXI4-Stream frame FIFO, frames are released only after a good tlast
// output tuser is not provided, sizes come from frame_fifo_macros.svh
`include "frame_fifo_macros.svh"
`default_nettype none

module axis_async_frame_fifo_64 (
    input  wire                         async_rst,
    input  wire                         input_clk,
    input  wire axis_stream_pkg::data_t input_axis_tdata,
    input  wire axis_stream_pkg::keep_t input_axis_tkeep,
    input  wire                         input_axis_tvalid,
    output wire                         input_axis_tready,
    input  wire                         input_axis_tlast,
    input  wire                         input_axis_tuser,
    input  wire                         output_clk,
    output wire axis_stream_pkg::data_t output_axis_tdata,
    output wire axis_stream_pkg::keep_t output_axis_tkeep,
    output wire                         output_axis_tvalid,
    input  wire                         output_axis_tready,
    output wire                         output_axis_tlast,
    output wire                         input_status_overflow,
    output wire                         input_status_bad_frame,
    output wire                         input_status_good_frame,
    output wire                         output_status_overflow,
    output wire                         output_status_bad_frame,
    output wire                         output_status_good_frame
);
    import axis_stream_pkg::*;
    import fifo_ctrl_pkg::*;

    wire             input_rst;
    wire             output_rst;
    wire ptr_t       wr_ptr_gray;
    wire ptr_t       rd_ptr_gray;
    wire             ram_wr_en;
    wire addr_t      ram_wr_addr;
    wire fifo_word_t ram_wr_data;
    wire             ram_rd_en;
    wire addr_t      ram_rd_addr;
    wire fifo_word_t ram_rd_data;

    fifo_reset_sync reset_sync_inst (
        .async_rst(async_rst), .input_clk(input_clk), .output_clk(output_clk),
        .input_rst(input_rst), .output_rst(output_rst)
    );

    frame_write_ctrl write_ctrl_inst (
        .input_clk(input_clk), .input_rst(input_rst),
        .input_axis_tdata(input_axis_tdata), .input_axis_tkeep(input_axis_tkeep),
        .input_axis_tvalid(input_axis_tvalid), .input_axis_tlast(input_axis_tlast),
        .input_axis_tuser(input_axis_tuser), .input_axis_tready(input_axis_tready),
        .rd_ptr_gray(rd_ptr_gray), .wr_ptr_gray(wr_ptr_gray),
        .ram_wr_en(ram_wr_en), .ram_wr_addr(ram_wr_addr), .ram_wr_data(ram_wr_data),
        .status_good(input_status_good_frame), .status_bad(input_status_bad_frame),
        .status_overflow(input_status_overflow)
    );

    frame_fifo_ram ram_inst (
        .input_clk(input_clk), .output_clk(output_clk),
        .ram_wr_en(ram_wr_en), .ram_wr_addr(ram_wr_addr), .ram_wr_data(ram_wr_data),
        .ram_rd_en(ram_rd_en), .ram_rd_addr(ram_rd_addr), .ram_rd_data(ram_rd_data)
    );

    frame_read_ctrl read_ctrl_inst (
        .output_clk(output_clk), .output_rst(output_rst),
        .wr_ptr_gray(wr_ptr_gray), .rd_ptr_gray(rd_ptr_gray),
        .ram_rd_en(ram_rd_en), .ram_rd_addr(ram_rd_addr), .ram_rd_data(ram_rd_data),
        .output_axis_tdata(output_axis_tdata), .output_axis_tkeep(output_axis_tkeep),
        .output_axis_tvalid(output_axis_tvalid), .output_axis_tlast(output_axis_tlast),
        .output_axis_tready(output_axis_tready)
    );

    frame_status_sync status_sync_inst (
        .input_clk(input_clk), .input_rst(input_rst),
        .output_clk(output_clk), .output_rst(output_rst),
        .status_good(input_status_good_frame), .status_bad(input_status_bad_frame),
        .status_overflow(input_status_overflow),
        .output_status_good(output_status_good_frame),
        .output_status_bad(output_status_bad_frame),
        .output_status_overflow(output_status_overflow)
    );
endmodule

`default_nettype wire

// ==== tb/tb_axis_async_frame_fifo_64.sv ====
// table-driven testbench for the dual-clock frame FIFO
// frame lengths assume the default 64-word memory, so the 70-beat frame must overflow
`default_nettype none

module tb_axis_async_frame_fifo_64;
    timeunit 1ns;
    timeprecision 1ps;

    import axis_stream_pkg::*;

    localparam int NUM_FRAMES    = 7;
    localparam int BEAT_TIMEOUT  = 1000;
    localparam int RESET_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int EVENT_TIMEOUT = 100;

    logic  async_rst;
    logic  input_clk;
    logic  output_clk;
    data_t input_axis_tdata;
    keep_t input_axis_tkeep;
    logic  input_axis_tvalid;
    logic  input_axis_tready;
    logic  input_axis_tlast;
    logic  input_axis_tuser;
    data_t output_axis_tdata;
    keep_t output_axis_tkeep;
    logic  output_axis_tvalid;
    logic  output_axis_tready;
    logic  output_axis_tlast;
    logic  input_status_overflow;
    logic  input_status_bad_frame;
    logic  input_status_good_frame;
    logic  output_status_overflow;
    logic  output_status_bad_frame;
    logic  output_status_good_frame;

    // frame length, tuser on the last beat, expected outcome
    int           frame_len  [NUM_FRAMES] = '{1, 3, 8, 4, 5, 70, 6};
    logic         frame_user [NUM_FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    frame_event_e frame_ev   [NUM_FRAMES] = '{EV_GOOD, EV_GOOD, EV_GOOD, EV_BAD,
                                              EV_GOOD, EV_OVERFLOW, EV_GOOD};

    // beats of good frames, oldest first
    data_t  exp_data [$];
    keep_t  exp_keep [$];
    logic   exp_last [$];
    integer seed = 32'h6e5995b9;
    int     mismatches = 0;
    int     timeouts = 0;
    int     in_good = 0;
    int     in_bad = 0;
    int     in_ovf = 0;
    int     out_good = 0;
    int     out_bad = 0;
    int     out_ovf = 0;

    axis_async_frame_fifo_64 axis_async_frame_fifo_64_inst (.*);

    initial begin
        input_clk = 1'b0;
        forever #5 input_clk = ~input_clk;
    end

    initial begin
        output_clk = 1'b0;
        forever #4 output_clk = ~output_clk;
    end

    // sink ready about three cycles in four
    always @(posedge output_clk) begin
        output_axis_tready <= (($random(seed) & 3) != 0);
    end

    // pulses last one cycle, counted mid-cycle
    always @(negedge input_clk) begin
        in_good += int'(input_status_good_frame === 1'b1);
        in_bad  += int'(input_status_bad_frame === 1'b1);
        in_ovf  += int'(input_status_overflow === 1'b1);
    end

    always @(negedge output_clk) begin
        out_good += int'(output_status_good_frame === 1'b1);
        out_bad  += int'(output_status_bad_frame === 1'b1);
        out_ovf  += int'(output_status_overflow === 1'b1);
        if (output_axis_tvalid === 1'b1 && output_axis_tready === 1'b1) begin
            check_beat(output_axis_tdata, output_axis_tkeep, output_axis_tlast);
        end
    end

    function automatic frame_event_e status_event(input logic good, input logic bad,
                                                  input logic ovf);
        case ({ovf, bad, good})
            3'b001:  return EV_GOOD;
            3'b010:  return EV_BAD;
            3'b100:  return EV_OVERFLOW;
            default: return EV_NONE;
        endcase
    endfunction

    task automatic check_beat(input data_t got_data, input keep_t got_keep,
                              input logic got_last);
        data_t want_data;
        keep_t want_keep;
        logic  want_last;
        if (exp_data.size() == 0) begin
            mismatches++;
            $display("FAILED @ %0t: unexpected output beat %h", $time, got_data);
        end else begin
            want_data = exp_data.pop_front();
            want_keep = exp_keep.pop_front();
            want_last = exp_last.pop_front();
            if (got_data !== want_data || got_keep !== want_keep || got_last !== want_last) begin
                mismatches++;
                $display("FAILED @ %0t: beat %h/%h/%b, expected %h/%h/%b", $time,
                         got_data, got_keep, got_last, want_data, want_keep, want_last);
            end
        end
    endtask

    task automatic check_event(input int frame, input frame_event_e want,
                               input frame_event_e got);
        if (got !== want) begin
            mismatches++;
            $display("FAILED @ %0t: frame %0d gave status %s, expected %s", $time,
                     frame, got.name(), want.name());
        end
    endtask

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            mismatches++;
            $display("FAILED @ %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_idle(input string phase);
        logic [7:0] busy;
        busy = {input_axis_tready, output_axis_tvalid,
                input_status_good_frame, input_status_bad_frame, input_status_overflow,
                output_status_good_frame, output_status_bad_frame, output_status_overflow};
        if (busy !== 8'h00) begin
            mismatches++;
            $display("FAILED @ %0t: outputs active %s, got %b", $time, phase, busy);
        end
    endtask

    // returns at the negedge before the edge that takes the beat
    task automatic send_beat(input int frame, input int beat, input data_t data,
                             input keep_t keep, input logic last, input logic user);
        int waited;
        @(posedge input_clk);
        input_axis_tdata  <= data;
        input_axis_tkeep  <= keep;
        input_axis_tlast  <= last;
        input_axis_tuser  <= user;
        input_axis_tvalid <= 1'b1;
        waited = 0;
        @(negedge input_clk);
        while (input_axis_tready !== 1'b1 && waited < BEAT_TIMEOUT) begin
            @(negedge input_clk);
            waited++;
        end
        if (input_axis_tready !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t: input tready stayed low on frame %0d beat %0d",
                     $time, frame, beat);
        end
    endtask

    task automatic send_frame(input int frame);
        data_t data;
        keep_t keep;
        logic  last;
        for (int b = 0; b < frame_len[frame]; b++) begin
            data = {$random(seed), $random(seed)};
            last = (b == frame_len[frame] - 1);
            keep = '1;
            if (last) begin
                keep = keep >> (frame_len[frame] % $bits(keep_t));
            end
            if (frame_ev[frame] == EV_GOOD) begin
                exp_data.push_back(data);
                exp_keep.push_back(keep);
                exp_last.push_back(last);
            end
            send_beat(frame, b, data, keep, last, last && frame_user[frame]);
        end
        @(posedge input_clk);
        input_axis_tvalid <= 1'b0;
        input_axis_tlast  <= 1'b0;
        input_axis_tuser  <= 1'b0;
        // status belongs to the cycle right after the last transfer
        @(negedge input_clk);
        check_event(frame, frame_ev[frame], status_event(input_status_good_frame,
                    input_status_bad_frame, input_status_overflow));
    endtask

    initial begin
        int waited;
        int exp_good;
        int exp_bad;
        int exp_ovf;
        async_rst          = 1'b1;
        input_axis_tdata   = '0;
        input_axis_tkeep   = '0;
        input_axis_tvalid  = 1'b0;
        input_axis_tlast   = 1'b0;
        input_axis_tuser   = 1'b0;
        output_axis_tready = 1'b0;
        exp_good = 0;
        exp_bad  = 0;
        exp_ovf  = 0;

        repeat (4) @(posedge output_clk);
        @(negedge output_clk);
        check_idle("during reset");
        @(posedge output_clk);
        async_rst <= 1'b0;

        // outputs stay quiet until the input side opens
        waited = 0;
        @(negedge input_clk);
        while (input_axis_tready !== 1'b1 && waited < RESET_TIMEOUT) begin
            check_idle("before reset release");
            @(negedge input_clk);
            waited++;
        end
        if (input_axis_tready !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t: input tready never rose after reset", $time);
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
            exp_good += int'(frame_ev[f] == EV_GOOD);
            exp_bad  += int'(frame_ev[f] == EV_BAD);
            exp_ovf  += int'(frame_ev[f] == EV_OVERFLOW);
        end

        waited = 0;
        while (exp_data.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge output_clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            timeouts++;
            $display("timeout at %0t: good frames did not fully drain", $time);
        end

        waited = 0;
        while ((out_good != in_good || out_bad != in_bad || out_ovf != in_ovf) &&
               waited < EVENT_TIMEOUT) begin
            @(negedge output_clk);
            waited++;
        end
        if (out_good != in_good || out_bad != in_bad || out_ovf != in_ovf) begin
            timeouts++;
            $display("timeout at %0t: output status pulses never caught up", $time);
        end

        // idle time to catch stray beats
        repeat (20) @(negedge output_clk);
        check_count("input good pulses", in_good, exp_good);
        check_count("input bad pulses", in_bad, exp_bad);
        check_count("input overflow pulses", in_ovf, exp_ovf);
        check_count("output good pulses", out_good, in_good);
        check_count("output bad pulses", out_bad, in_bad);
        check_count("output overflow pulses", out_ovf, in_ovf);
        check_count("beats left in queue", exp_data.size(), 0);

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/axis_stream_pkg.sv
verilog/fifo_ctrl_pkg.sv
verilog/fifo_reset_sync.sv
verilog/frame_fifo_ram.sv
verilog/frame_write_ctrl.sv
verilog/frame_read_ctrl.sv
verilog/frame_status_sync.sv
verilog/axis_async_frame_fifo_64.sv
tb/tb_axis_async_frame_fifo_64.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame FIFO testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axis_async_frame_fifo_64 -Mdir obj_dir -o tb_sim \
    -f verilog.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
